//--- tlu_params.svh
// widths, depth, register map and version of the trigger controller, included by package and RTL
`ifndef TLU_PARAMS_SVH
`define TLU_PARAMS_SVH

// bus geometry
`define TLU_ABUS_WIDTH      16
`define TLU_DBUS_WIDTH      8

// trigger and veto lines
`define TLU_NUM_INPUTS      8

// output buffer depth in trigger words
`define TLU_FIFO_DEPTH      8

// flops per input synchronizer
`define TLU_SYNC_STAGES     3

`define TLU_VERSION         3   // read back at address 0

// register map
`define TLU_ADDR_RESET      0   // write: soft reset, read: version
`define TLU_ADDR_CNT0       8   // counter bits 7:0, read snapshots the upper bytes
`define TLU_ADDR_CNT1       9
`define TLU_ADDR_CNT2       10
`define TLU_ADDR_CNT3       11  // write loads the whole counter
`define TLU_ADDR_LOST       12
`define TLU_ADDR_TRG_SEL    13
`define TLU_ADDR_VETO_SEL   14
`define TLU_ADDR_TRG_INV    15

`endif

//--- tlu_pkg.sv
// shared types of the trigger controller, imported by the interface and RTL modules
`include "tlu_params.svh"

package tlu_pkg;

    // register bus
    typedef logic [`TLU_ABUS_WIDTH-1:0] bus_addr_t;
    typedef logic [`TLU_DBUS_WIDTH-1:0] bus_data_t;

    typedef logic [`TLU_NUM_INPUTS-1:0] line_mask_t;   // one bit per input line

    // counters
    typedef logic [31:0] trg_count_t;
    typedef logic [7:0]  lost_count_t;     // saturates, never wraps

    // word pushed into the output FIFO on every accepted trigger
    typedef struct packed {
        logic        marker;    // always set, tells trigger words apart downstream
        logic [30:0] number;    // counter value before the increment
    } trg_word_t;

    // accept/acknowledge machine
    typedef enum logic {
        idle,
        wait_ack
    } trg_state_t;

endpackage

//--- tlu_cfg_if.sv
// configuration and status between the register decode and the trigger datapath modules
`timescale 1ns/1ps

interface tlu_cfg_if;
    import tlu_pkg::*;

    // masks from the register bank
    line_mask_t  trg_select;
    line_mask_t  veto_select;
    line_mask_t  trg_invert;

    logic        cnt_load;          // one cycle, with the full value alongside
    trg_count_t  cnt_load_value;

    // status back to the register bank
    trg_count_t  trg_count;
    lost_count_t lost_count;

    modport regs (
        output trg_select, veto_select, trg_invert, cnt_load, cnt_load_value,
        input  trg_count, lost_count
    );

    modport trig_in (
        input trg_select, veto_select, trg_invert
    );

    modport fsm (
        input  cnt_load, cnt_load_value,
        output trg_count
    );

    modport fifo (
        output lost_count
    );

endinterface

//--- tlu_regs.sv
// register bank of the trigger controller: write decode, registered read mux, soft reset
`timescale 1ns/1ps
`include "tlu_params.svh"

module tlu_regs
(
    input  logic               bus_clk,
    input  logic               rst,
    input  tlu_pkg::bus_addr_t bus_add,
    input  tlu_pkg::bus_data_t bus_data_in,
    input  logic               bus_rd,
    input  logic               bus_wr,
    output tlu_pkg::bus_data_t bus_data_out,
    output logic               srst,
    tlu_cfg_if.regs            cfg
);
    import tlu_pkg::*;

    line_mask_t  trg_select;
    line_mask_t  veto_select;
    line_mask_t  trg_invert;
    bus_data_t   cnt_set [3];   // low bytes staged for a counter load
    logic [23:0] cnt_buf;       // counter bits 31:8, frozen by a read of byte 0

    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            trg_select  <= '0;
            veto_select <= '1;      // every veto line active by default
            trg_invert  <= '0;
            cnt_set[0]  <= '0;
            cnt_set[1]  <= '0;
            cnt_set[2]  <= '0;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                `TLU_ADDR_CNT0:     cnt_set[0]  <= bus_data_in;
                `TLU_ADDR_CNT1:     cnt_set[1]  <= bus_data_in;
                `TLU_ADDR_CNT2:     cnt_set[2]  <= bus_data_in;
                `TLU_ADDR_TRG_SEL:  trg_select  <= bus_data_in;
                `TLU_ADDR_VETO_SEL: veto_select <= bus_data_in;
                `TLU_ADDR_TRG_INV:  trg_invert  <= bus_data_in;
                default:            ;
            endcase
        end
    end

    // soft reset, one cycle after the write to address 0
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            srst <= 1'b0;
        else
            srst <= bus_wr && (bus_add == `TLU_ADDR_RESET);
    end

    // snapshot so that a multi-byte read sees one consistent value
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            cnt_buf <= '0;
        else if (bus_rd && (bus_add == `TLU_ADDR_CNT0))
            cnt_buf <= cfg.trg_count[31:8];
    end

    always_ff @(posedge bus_clk)
    begin
        case (bus_add)
            `TLU_ADDR_RESET:    bus_data_out <= bus_data_t'(`TLU_VERSION);
            `TLU_ADDR_CNT0:     bus_data_out <= cfg.trg_count[7:0];  // live byte
            `TLU_ADDR_CNT1:     bus_data_out <= cnt_buf[7:0];
            `TLU_ADDR_CNT2:     bus_data_out <= cnt_buf[15:8];
            `TLU_ADDR_CNT3:     bus_data_out <= cnt_buf[23:16];
            `TLU_ADDR_LOST:     bus_data_out <= cfg.lost_count;
            `TLU_ADDR_TRG_SEL:  bus_data_out <= trg_select;
            `TLU_ADDR_VETO_SEL: bus_data_out <= veto_select;
            `TLU_ADDR_TRG_INV:  bus_data_out <= trg_invert;
            default:            bus_data_out <= '0;
        endcase
    end

    // writing the top byte commits all four bytes at once
    assign cfg.cnt_load       = bus_wr && (bus_add == `TLU_ADDR_CNT3);
    assign cfg.cnt_load_value = {bus_data_in, cnt_set[2], cnt_set[1], cnt_set[0]};

    assign cfg.trg_select  = trg_select;
    assign cfg.veto_select = veto_select;
    assign cfg.trg_invert  = trg_invert;

endmodule

//--- tlu_trigger_input.sv
// trigger and veto conditioning: invert, select, OR, synchronize and rising-edge detect
`timescale 1ns/1ps
`include "tlu_params.svh"

module tlu_trigger_input
(
    input  logic                bus_clk,
    input  logic                rst,
    input  tlu_pkg::line_mask_t trigger,
    input  tlu_pkg::line_mask_t trigger_veto,
    output logic                trg_edge,
    output logic                veto,
    tlu_cfg_if.trig_in          cfg
);
    logic       trg_or;
    logic       veto_or;
    logic [1:0] sync_q [`TLU_SYNC_STAGES];  // bit 0 trigger, bit 1 veto
    logic       trg_prev;

    // invert first, then mask, so an unselected line can never fire
    assign trg_or  = |((trigger ^ cfg.trg_invert) & cfg.trg_select);
    assign veto_or = |(trigger_veto & cfg.veto_select);

    // both ORs share one synchronizer chain
    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `TLU_SYNC_STAGES; i++)
                sync_q[i] <= '0;
            trg_prev <= 1'b0;
        end
        else
        begin
            sync_q[0] <= {veto_or, trg_or};
            for (int i = 1; i < `TLU_SYNC_STAGES; i++)
                sync_q[i] <= sync_q[i-1];
            trg_prev <= sync_q[`TLU_SYNC_STAGES-1][0];   // edge stage
        end
    end

    assign trg_edge = sync_q[`TLU_SYNC_STAGES-1][0] & ~trg_prev;
    assign veto     = sync_q[`TLU_SYNC_STAGES-1][1];

endmodule

//--- tlu_trigger_fsm.sv
// trigger accept/acknowledge state machine with the trigger counter and word builder
`timescale 1ns/1ps

module tlu_trigger_fsm
(
    input  logic               bus_clk,
    input  logic               rst,
    input  logic               trg_edge,
    input  logic               veto,
    input  logic               trigger_enable,
    input  logic               trigger_acknowledge,
    output logic               trigger_accepted_flag,
    output logic               tlu_busy,
    output logic               wr,
    output tlu_pkg::trg_word_t wr_data,
    tlu_cfg_if.fsm             cfg
);
    import tlu_pkg::*;

    trg_state_t state;
    trg_state_t state_next;
    trg_count_t count;
    logic       accept;

    // only a fresh edge in idle counts, edges while busy are lost on purpose
    assign accept = (state == idle) && trg_edge && trigger_enable && !veto;

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
            begin
                if (accept)
                    state_next = wait_ack;
            end
            wait_ack:
            begin
                if (trigger_acknowledge)
                    state_next = idle;
            end
            default:
                state_next = idle;
        endcase
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst)
            state <= idle;
        else
            state <= state_next;
    end

    // a bus load wins over a trigger in the same cycle
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            count <= '0;
        else if (cfg.cnt_load)
            count <= cfg.cnt_load_value;
        else if (accept)
            count <= count + 1'b1;
    end

    always_comb
    begin
        wr_data.marker = 1'b1;
        wr_data.number = count[30:0];   // value before the increment
    end

    assign wr                    = accept;
    assign trigger_accepted_flag = accept;
    assign tlu_busy              = (state == wait_ack);
    assign cfg.trg_count         = count;

endmodule

//--- tlu_event_fifo.sv
// show-ahead output FIFO of trigger words with a saturating count of dropped writes
`timescale 1ns/1ps
`include "tlu_params.svh"

module tlu_event_fifo
(
    input  logic               bus_clk,
    input  logic               rst,
    input  logic               wr,
    input  tlu_pkg::trg_word_t wr_data,
    input  logic               fifo_read,
    output logic               fifo_empty,
    output tlu_pkg::trg_word_t fifo_data,
    tlu_cfg_if.fifo            cfg
);
    import tlu_pkg::*;

    localparam int ptr_width = $clog2(`TLU_FIFO_DEPTH);

    trg_word_t            mem [`TLU_FIFO_DEPTH];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width:0]   fill;     // words held, 0 to depth
    logic                 full;
    logic                 do_wr;
    logic                 do_rd;
    lost_count_t          lost;

    assign full       = (fill == `TLU_FIFO_DEPTH);
    assign fifo_empty = (fill == 0);
    assign do_wr      = wr && !full;        // full writes are dropped
    assign do_rd      = fifo_read && !fifo_empty;

    always_ff @(posedge bus_clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == `TLU_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == `TLU_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;                      // none or both
            endcase
        end
    end

    always_ff @(posedge bus_clk)
    begin
        if (rst)
            lost <= '0;
        else if (wr && full && (lost != '1))   // stick at 255
            lost <= lost + 1'b1;
    end

    assign fifo_data      = mem[rd_ptr];   // oldest word, valid while not empty
    assign cfg.lost_count = lost;

endmodule

//--- tlu_controller.sv
// top level of the single-clock trigger controller, wires register bank, input path, FSM, FIFO
`timescale 1ns/1ps

module tlu_controller
(
    input  logic                BUS_CLK,
    input  logic                RST,
    input  tlu_pkg::bus_addr_t  bus_add,
    input  tlu_pkg::bus_data_t  bus_data_in,
    input  logic                bus_rd,
    input  logic                bus_wr,
    output tlu_pkg::bus_data_t  bus_data_out,
    input  tlu_pkg::line_mask_t trigger,
    input  tlu_pkg::line_mask_t trigger_veto,
    input  logic                trigger_enable,
    input  logic                trigger_acknowledge,
    output logic                trigger_accepted_flag,
    output logic                tlu_busy,
    input  logic                fifo_read,
    output logic                fifo_empty,
    output logic [31:0]         fifo_data
);
    import tlu_pkg::*;

    logic      srst;
    logic      rst;         // hard or soft reset, for every block
    logic      trg_edge;
    logic      veto;
    logic      wr;
    trg_word_t wr_data;

    assign rst = RST | srst;

    tlu_cfg_if cfg ();

    tlu_regs i_tlu_regs (
        .bus_clk      (BUS_CLK),
        .rst          (rst),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .srst         (srst),
        .cfg          (cfg.regs)
    );

    tlu_trigger_input i_tlu_trigger_input (
        .bus_clk      (BUS_CLK),
        .rst          (rst),
        .trigger      (trigger),
        .trigger_veto (trigger_veto),
        .trg_edge     (trg_edge),
        .veto         (veto),
        .cfg          (cfg.trig_in)
    );

    tlu_trigger_fsm i_tlu_trigger_fsm (
        .bus_clk               (BUS_CLK),
        .rst                   (rst),
        .trg_edge              (trg_edge),
        .veto                  (veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag),
        .tlu_busy              (tlu_busy),
        .wr                    (wr),
        .wr_data               (wr_data),
        .cfg                   (cfg.fsm)
    );

    tlu_event_fifo i_tlu_event_fifo (
        .bus_clk    (BUS_CLK),
        .rst        (rst),
        .wr         (wr),
        .wr_data    (wr_data),
        .fifo_read  (fifo_read),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),    // marker in bit 31
        .cfg        (cfg.fifo)
    );

endmodule

//--- tb_tlu_controller.sv
// drives bus and trigger lines of the trigger controller and checks the outputs against a reference model
`timescale 1ns/1ps
`include "tlu_params.svh"

module tb_tlu_controller;
    import tlu_pkg::*;

    localparam int window  = 12;    // cycles watched per trigger pulse
    localparam int timeout = 50;

    logic        BUS_CLK;
    logic        RST;
    bus_addr_t   bus_add;
    bus_data_t   bus_data_in;
    bus_data_t   bus_data_out;
    logic        bus_rd;
    logic        bus_wr;
    line_mask_t  trigger;
    line_mask_t  trigger_veto;
    logic        trigger_enable;
    logic        trigger_acknowledge;
    logic        trigger_accepted_flag;
    logic        tlu_busy;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;

    logic [31:0] rng_state = 32'hc986_45df;
    line_mask_t  trigger_idle;      // resting level of the trigger lines
    trg_count_t  model_count;
    int          model_lost;
    logic [31:0] exp_q [$];         // expected FIFO words in arrival order
    int          line;
    line_mask_t  sel;
    trg_count_t  load_value;

    tlu_controller i_tlu_controller (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #10 BUS_CLK = ~BUS_CLK;
    end

    flag_not_while_busy: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(trigger_accepted_flag && tlu_busy))
        else stop_with_failure("trigger_accepted_flag was high while tlu_busy was high");

    // every buffered word carries the marker
    marker_in_word: assert property (@(posedge BUS_CLK) disable iff (RST)
        !fifo_empty |-> fifo_data[31])
        else stop_with_failure("FIFO word without marker bit while fifo_empty is low");

    task stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else stop_with_failure($sformatf("error: at %0t ns %s is %h, expected %h",
                                         $time, name, got, exp));
    endtask

    function logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task next_cycle();
        @(posedge BUS_CLK);
        #2;
    endtask

    task bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        next_cycle();
        bus_wr      = 1'b0;
    endtask

    // data comes back one edge after the address
    task read_expect(input bus_addr_t addr, input bus_data_t exp);
        bus_add = addr;
        bus_rd  = 1'b1;
        next_cycle();
        bus_rd  = 1'b0;
        check_value($sformatf("bus_data_out at address %0d", addr), bus_data_out, exp);
    endtask

    task model_accept();
        if (exp_q.size() < `TLU_FIFO_DEPTH)
            exp_q.push_back({1'b1, model_count[30:0]});
        else if (model_lost < 255)
            model_lost++;                   // full FIFO drops the word
        model_count++;
    endtask

    // 3-cycle pulse and a count of accepted flags over the window
    task fire_trigger(input line_mask_t mask, input bit expect_accept);
        int flags;
        flags   = 0;
        trigger = trigger_idle ^ mask;
        for (int i = 0; i < window; i++)
        begin
            if (i == 3)
                trigger = trigger_idle;
            next_cycle();
            if (trigger_accepted_flag)
                flags++;
        end
        check_value("trigger_accepted_flag pulse count", flags, expect_accept);
        if (expect_accept)
            model_accept();
    endtask

    task acknowledge();
        for (int i = 0; i < timeout && !tlu_busy; i++)
            next_cycle();
        if (!tlu_busy)
            stop_with_failure("timeout while waiting for tlu_busy to rise");
        trigger_acknowledge = 1'b1;
        next_cycle();
        trigger_acknowledge = 1'b0;
        check_value("tlu_busy", tlu_busy, 1'b0);
    endtask

    // pops and compares every word the model expects
    task drain_fifo();
        logic [31:0] word;
        while (exp_q.size() > 0)
        begin
            word = exp_q.pop_front();
            check_value("fifo_empty", fifo_empty, 1'b0);
            check_value("fifo_data", fifo_data, word);
            fifo_read = 1'b1;
            next_cycle();
            fifo_read = 1'b0;
        end
        check_value("fifo_empty", fifo_empty, 1'b1);
    endtask

    initial
    begin
        RST                 = 1'b1;
        bus_add             = '0;
        bus_data_in         = '0;
        bus_rd              = 1'b0;
        bus_wr              = 1'b0;
        trigger_idle        = '0;
        trigger             = '0;
        trigger_veto        = '0;
        trigger_enable      = 1'b1;
        trigger_acknowledge = 1'b0;
        fifo_read           = 1'b0;
        model_count         = '0;
        model_lost          = 0;
        repeat (3) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;

        read_expect(`TLU_ADDR_RESET, 8'h03);
        read_expect(`TLU_ADDR_VETO_SEL, 8'hff);
        read_expect(`TLU_ADDR_TRG_SEL, 8'h00);
        read_expect(`TLU_ADDR_TRG_INV, 8'h00);
        read_expect(`TLU_ADDR_LOST, 8'h00);
        check_value("fifo_empty", fifo_empty, 1'b1);
        check_value("tlu_busy", tlu_busy, 1'b0);

        fire_trigger('1, 1'b0);             // nothing selected yet
        line      = next_random() % `TLU_NUM_INPUTS;
        sel       = '0;
        sel[line] = 1'b1;
        bus_write(`TLU_ADDR_TRG_SEL, sel);
        fire_trigger(sel, 1'b1);
        acknowledge();
        drain_fifo();

        // inverted line rests high and stays deselected while it settles
        bus_write(`TLU_ADDR_TRG_SEL, '0);
        trigger_idle = sel;
        trigger      = trigger_idle;
        bus_write(`TLU_ADDR_TRG_INV, sel);
        bus_write(`TLU_ADDR_TRG_SEL, sel);
        fire_trigger(sel, 1'b1);            // low-going pulse
        acknowledge();
        drain_fifo();
        bus_write(`TLU_ADDR_TRG_SEL, '0);
        trigger_idle = '0;
        trigger      = '0;
        bus_write(`TLU_ADDR_TRG_INV, '0);
        bus_write(`TLU_ADDR_TRG_SEL, sel);

        trigger_veto = sel;
        fire_trigger(sel, 1'b0);
        bus_write(`TLU_ADDR_VETO_SEL, ~sel);
        fire_trigger(sel, 1'b1);
        acknowledge();
        drain_fifo();
        trigger_veto = '0;
        bus_write(`TLU_ADDR_VETO_SEL, '1);

        trigger_enable = 1'b0;
        fire_trigger(sel, 1'b0);
        trigger_enable = 1'b1;

        fire_trigger(sel, 1'b1);
        fire_trigger(sel, 1'b0);            // ignored while busy
        fire_trigger(sel, 1'b0);
        acknowledge();
        fire_trigger(sel, 1'b1);
        acknowledge();
        drain_fifo();

        load_value = next_random();
        bus_write(`TLU_ADDR_CNT0, load_value[7:0]);
        bus_write(`TLU_ADDR_CNT1, load_value[15:8]);
        bus_write(`TLU_ADDR_CNT2, load_value[23:16]);
        bus_write(`TLU_ADDR_CNT3, load_value[31:24]);
        model_count = load_value;
        fire_trigger(sel, 1'b1);
        acknowledge();
        drain_fifo();
        read_expect(`TLU_ADDR_CNT0, model_count[7:0]);
        read_expect(`TLU_ADDR_CNT1, model_count[15:8]);
        read_expect(`TLU_ADDR_CNT2, model_count[23:16]);
        read_expect(`TLU_ADDR_CNT3, model_count[31:24]);

        repeat (10)
        begin
            fire_trigger(sel, 1'b1);
            acknowledge();
        end
        read_expect(`TLU_ADDR_LOST, model_lost);
        drain_fifo();

        // soft reset with a word still buffered
        fire_trigger(sel, 1'b1);
        acknowledge();
        check_value("fifo_empty", fifo_empty, 1'b0);
        bus_write(`TLU_ADDR_RESET, '0);
        for (int i = 0; i < timeout && !fifo_empty; i++)
            next_cycle();
        if (!fifo_empty)
            stop_with_failure("fifo_empty did not rise after the soft reset");
        exp_q.delete();
        model_count = '0;
        model_lost  = 0;
        read_expect(`TLU_ADDR_LOST, model_lost);
        read_expect(`TLU_ADDR_CNT0, model_count[7:0]);
        read_expect(`TLU_ADDR_TRG_SEL, 8'h00);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tlu_controller.f
+incdir+.
tlu_pkg.sv
tlu_cfg_if.sv
tlu_regs.sv
tlu_trigger_input.sv
tlu_trigger_fsm.sv
tlu_event_fifo.sv
tlu_controller.sv
tb_tlu_controller.sv
